// ==== hw/mmio_pkg.sv ====
package mmio_pkg;

	// Bus widths
	localparam int addr_width = 32;
	localparam int data_width = 32;

	// RAM word select uses address bits 11:0
	localparam int ram_addr_bits = 12;

	// Everything at or above the base is I/O
	localparam logic [addr_width-1:0] mmio_base = 32'h2000;

	// I/O register map
	localparam logic [addr_width-1:0] mmio_id_addr = 32'h2000;
	localparam logic [addr_width-1:0] mmio_rng_addr = 32'h2001;
	localparam logic [addr_width-1:0] mmio_midi_addr = 32'h2002;
	localparam logic [addr_width-1:0] mmio_display_addr = 32'h2003;

	// Fixed identification word
	localparam logic [data_width-1:0] id_word = 32'hFBADC0DE;

	// Xorshift start state, must be nonzero
	localparam logic [data_width-1:0] rng_seed = 32'hDEADBEEF;

	// Clocks per digit, 1 kHz digit rate at 100 MHz
	localparam int scan_cycles = 100000;

endpackage

// ==== hw/midi_pkg.sv ====
package midi_pkg;

	// 31250 baud at 100 MHz
	localparam int midi_bit_cycles = 3200;

	// Frame is start, eight data bits LSB first, stop
	localparam int midi_data_bits = 8;

	// Status byte plus two data bytes
	localparam int midi_msg_bytes = 3;

	// Set on status bytes only
	localparam int midi_status_bit = 7;

endpackage

// ==== hw/data_ram.sv ====
`timescale 1ns/1ns

module data_ram (
	input  logic CLK100MHZ,
	input  logic ram_wen,
	input  logic ram_ren,
	input  logic [mmio_pkg::ram_addr_bits-1:0] ram_addr,
	input  logic [mmio_pkg::data_width-1:0] ram_wdata,
	output logic [mmio_pkg::data_width-1:0] ram_rdata
);
	import mmio_pkg::*;

	// 4096 words, maps onto block RAM
	logic [data_width-1:0] mem [2**ram_addr_bits];

	// Write on the enable edge
	always_ff @(posedge CLK100MHZ) begin
		if (ram_wen) begin
			mem[ram_addr] <= ram_wdata;
		end
	end

	// Registered read
	// Output holds between reads
	always_ff @(posedge CLK100MHZ) begin
		if (ram_ren) begin
			ram_rdata <= mem[ram_addr];
		end
	end

endmodule

// ==== hw/xorshift_rng.sv ====
`timescale 1ns/1ns

module xorshift_rng (
	input  logic CLK100MHZ,
	input  logic reset,
	input  logic rng_next,
	output logic [mmio_pkg::data_width-1:0] rng_value
);
	import mmio_pkg::*;

	logic [data_width-1:0] state;
	logic [data_width-1:0] step_a;
	logic [data_width-1:0] step_b;
	logic [data_width-1:0] step_c;

	// One 13, 17, 5 xorshift step
	always_comb begin
		step_a = state ^ (state << 13);
		step_b = step_a ^ (step_a >> 17);
		step_c = step_b ^ (step_b << 5);
	end

	// Advance only on request
	always_ff @(posedge CLK100MHZ or posedge reset) begin
		if (reset) begin
			state <= rng_seed;
		end else if (rng_next) begin
			state <= step_c;
		end
	end

	// Current state, before any pending advance
	assign rng_value = state;

	// Zero is a fixed point, generator would lock up
	assert property (@(posedge CLK100MHZ) disable iff (reset) state != '0)
		else $error("xorshift state reached zero");

endmodule

// ==== hw/midi_receiver.sv ====
`timescale 1ns/1ns

module midi_receiver (
	input  logic CLK100MHZ,
	input  logic reset,
	input  logic midi_in,
	output logic [23:0] midi_msg,
	output logic midi_valid,
	output logic midi_busy
);
	import midi_pkg::*;

	localparam int cnt_w = $clog2(midi_bit_cycles);
	localparam int idx_w = $clog2(midi_data_bits);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_t;

	rx_state_t state;
	logic [1:0] sync;
	logic [cnt_w-1:0] bit_cnt;
	logic [idx_w-1:0] bit_idx;
	logic [7:0] shift;
	logic [1:0] byte_idx;
	logic [15:0] msg_buf;
	logic bit_done;
	logic half_done;
	logic byte_ok;

	// Line is idle high
	// sync[1] is the safe copy
	assign bit_done = bit_cnt == cnt_w'(midi_bit_cycles - 1);
	assign half_done = bit_cnt == cnt_w'(midi_bit_cycles / 2 - 1);
	// Good stop bit at mid-bit
	assign byte_ok = (state == st_stop) && bit_done && sync[1];
	assign midi_busy = state != st_idle;

	// Framing FSM
	always_ff @(posedge CLK100MHZ or posedge reset) begin
		if (reset) begin
			sync <= 2'b11;
			state <= st_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			sync <= {sync[0], midi_in};
			case (state)
				st_idle: begin
					bit_cnt <= '0;
					if (!sync[1]) begin
						state <= st_start;
					end
				end
				st_start: begin
					// Recheck at mid start bit, glitches go back to idle
					if (half_done) begin
						bit_cnt <= '0;
						bit_idx <= '0;
						state <= sync[1] ? st_idle : st_data;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				st_data: begin
					if (bit_done) begin
						bit_cnt <= '0;
						if (bit_idx == idx_w'(midi_data_bits - 1)) begin
							state <= st_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: begin
					// Stop bit, byte dropped if low
					if (bit_done) begin
						bit_cnt <= '0;
						state <= st_idle;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge CLK100MHZ) begin
		if (state == st_data && bit_done) begin
			shift <= {sync[1], shift[7:1]};
		end
	end

	// Message assembly
	// byte_idx 0 waits for a status byte
	always_ff @(posedge CLK100MHZ or posedge reset) begin
		if (reset) begin
			byte_idx <= '0;
			msg_buf <= '0;
			midi_msg <= '0;
			midi_valid <= 1'b0;
		end else begin
			midi_valid <= 1'b0;
			if (byte_ok) begin
				if (shift[midi_status_bit]) begin
					// Status always restarts
					msg_buf[15:8] <= shift;
					byte_idx <= 2'd1;
				end else if (byte_idx == 2'd1) begin
					msg_buf[7:0] <= shift;
					byte_idx <= 2'd2;
				end else if (byte_idx == 2'(midi_msg_bytes - 1)) begin
					midi_msg <= {msg_buf, shift};
					midi_valid <= 1'b1;
					byte_idx <= '0;
				end
				// Stray data bytes fall through
			end
		end
	end

	assert property (@(posedge CLK100MHZ) disable iff (reset)
		byte_idx <= 2'(midi_msg_bytes - 1))
		else $error("MIDI byte index out of range");

endmodule

// ==== hw/sevenseg_scanner.sv ====
`timescale 1ns/1ns

module sevenseg_scanner (
	input  logic CLK100MHZ,
	input  logic reset,
	input  logic [mmio_pkg::data_width-1:0] display_word,
	output logic [7:0] seg,
	output logic [7:0] an
);
	import mmio_pkg::*;

	localparam int cnt_w = $clog2(scan_cycles);

	logic [cnt_w-1:0] scan_cnt;
	logic [2:0] digit;
	logic active;
	logic [3:0] nibble;
	logic [6:0] pattern;

	// Dwell counter, then next digit
	always_ff @(posedge CLK100MHZ or posedge reset) begin
		if (reset) begin
			scan_cnt <= '0;
			digit <= '0;
			active <= 1'b0;
		end else begin
			// First cycle after reset keeps anodes dark
			active <= 1'b1;
			if (active) begin
				if (scan_cnt == cnt_w'(scan_cycles - 1)) begin
					scan_cnt <= '0;
					digit <= digit + 1'b1;
				end else begin
					scan_cnt <= scan_cnt + 1'b1;
				end
			end
		end
	end

	// Digit k shows nibble k
	assign nibble = display_word[digit*4 +: 4];

	// Hex font, bit 0 is segment a
	always_comb begin
		case (nibble)
			4'h0: pattern = 7'h3F;
			4'h1: pattern = 7'h06;
			4'h2: pattern = 7'h5B;
			4'h3: pattern = 7'h4F;
			4'h4: pattern = 7'h66;
			4'h5: pattern = 7'h6D;
			4'h6: pattern = 7'h7D;
			4'h7: pattern = 7'h07;
			4'h8: pattern = 7'h7F;
			4'h9: pattern = 7'h6F;
			4'hA: pattern = 7'h77;
			4'hB: pattern = 7'h7C;
			4'hC: pattern = 7'h39;
			4'hD: pattern = 7'h5E;
			4'hE: pattern = 7'h79;
			default: pattern = 7'h71;
		endcase
	end

	// Active low, decimal point off
	assign seg = {1'b1, ~pattern};
	// One anode low at a time
	assign an = active ? ~(8'b1 << digit) : 8'hFF;

endmodule

// ==== hw/mmio_bus.sv ====
`timescale 1ns/1ns

module mmio_bus (
	input  logic CLK100MHZ,
	input  logic reset,
	input  logic mem_ren,
	input  logic mem_wen,
	input  logic [mmio_pkg::addr_width-1:0] mem_addr,
	input  logic [mmio_pkg::data_width-1:0] mem_wdata,
	output logic [mmio_pkg::data_width-1:0] mem_rdata,
	output logic ram_wen,
	output logic ram_ren,
	output logic [mmio_pkg::ram_addr_bits-1:0] ram_addr,
	output logic [mmio_pkg::data_width-1:0] ram_wdata,
	input  logic [mmio_pkg::data_width-1:0] ram_rdata,
	output logic rng_next,
	input  logic [mmio_pkg::data_width-1:0] rng_value,
	input  logic [23:0] midi_msg,
	input  logic midi_valid,
	output logic [mmio_pkg::data_width-1:0] display_word,
	output logic [15:0] led
);
	import mmio_pkg::*;

	logic is_io;
	logic rd_io;
	logic [data_width-1:0] io_sel;
	logic [data_width-1:0] io_rdata;
	logic [23:0] midi_result;

	// RAM below the base, upper RAM half aliases
	assign is_io = mem_addr >= mmio_base;
	assign ram_wen = mem_wen && !is_io;
	assign ram_ren = mem_ren && !is_io;
	assign ram_addr = mem_addr[ram_addr_bits-1:0];
	assign ram_wdata = mem_wdata;

	// Advance on the same edge that captures the old value
	assign rng_next = mem_ren && (mem_addr == mmio_rng_addr);

	// I/O read select
	// Unmapped reads give zero
	always_comb begin
		case (mem_addr)
			mmio_id_addr: io_sel = id_word;
			mmio_rng_addr: io_sel = rng_value;
			mmio_midi_addr: io_sel = {8'd0, midi_result};
			mmio_display_addr: io_sel = display_word;
			default: io_sel = '0;
		endcase
	end

	// Source of the last read, plus captured I/O word
	always_ff @(posedge CLK100MHZ or posedge reset) begin
		if (reset) begin
			rd_io <= 1'b1;
			io_rdata <= '0;
		end else if (mem_ren) begin
			rd_io <= is_io;
			if (is_io) begin
				io_rdata <= io_sel;
			end
		end
	end

	// Both sources hold between reads
	assign mem_rdata = rd_io ? io_rdata : ram_rdata;

	// Display register, other I/O writes ignored
	always_ff @(posedge CLK100MHZ or posedge reset) begin
		if (reset) begin
			display_word <= '0;
		end else if (mem_wen && mem_addr == mmio_display_addr) begin
			display_word <= mem_wdata;
		end
	end

	// Last complete MIDI message
	always_ff @(posedge CLK100MHZ or posedge reset) begin
		if (reset) begin
			midi_result <= '0;
		end else if (midi_valid) begin
			midi_result <= midi_msg;
		end
	end

	assign led = midi_result[15:0];

	// Master must not read and write in one cycle
	assert property (@(posedge CLK100MHZ) disable iff (reset) !(mem_ren && mem_wen))
		else $error("bus read and write enables high together");

endmodule

// ==== hw/io_system.sv ====
`timescale 1ns/1ns

module io_system (
	input  logic CLK100MHZ,
	input  logic reset,
	input  logic mem_ren,
	input  logic mem_wen,
	input  logic [mmio_pkg::addr_width-1:0] mem_addr,
	input  logic [mmio_pkg::data_width-1:0] mem_wdata,
	output logic [mmio_pkg::data_width-1:0] mem_rdata,
	input  logic midi_in,
	output logic [15:0] led,
	output logic midi_busy,
	output logic [7:0] seg,
	output logic [7:0] an
);
	import mmio_pkg::*;

	// RAM side
	logic ram_wen;
	logic ram_ren;
	logic [ram_addr_bits-1:0] ram_addr;
	logic [data_width-1:0] ram_wdata;
	logic [data_width-1:0] ram_rdata;

	// Peripherals
	logic rng_next;
	logic [data_width-1:0] rng_value;
	logic [23:0] midi_msg;
	logic midi_valid;
	logic [data_width-1:0] display_word;

	// Decoder and I/O registers
	mmio_bus bus (
		.CLK100MHZ(CLK100MHZ),
		.reset(reset),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.ram_wen(ram_wen),
		.ram_ren(ram_ren),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.rng_next(rng_next),
		.rng_value(rng_value),
		.midi_msg(midi_msg),
		.midi_valid(midi_valid),
		.display_word(display_word),
		.led(led)
	);

	data_ram ram (
		.CLK100MHZ(CLK100MHZ),
		.ram_wen(ram_wen),
		.ram_ren(ram_ren),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	xorshift_rng rng (
		.CLK100MHZ(CLK100MHZ),
		.reset(reset),
		.rng_next(rng_next),
		.rng_value(rng_value)
	);

	// MIDI input is asynchronous to the clock
	midi_receiver midi (
		.CLK100MHZ(CLK100MHZ),
		.reset(reset),
		.midi_in(midi_in),
		.midi_msg(midi_msg),
		.midi_valid(midi_valid),
		.midi_busy(midi_busy)
	);

	sevenseg_scanner display (
		.CLK100MHZ(CLK100MHZ),
		.reset(reset),
		.display_word(display_word),
		.seg(seg),
		.an(an)
	);

endmodule

// ==== test/io_system_tb.sv ====
`timescale 1ns/1ns

module io_system_tb;
	import mmio_pkg::*;
	import midi_pkg::*;

	logic CLK100MHZ;
	logic reset;
	logic mem_ren;
	logic mem_wen;
	logic [addr_width-1:0] mem_addr;
	logic [data_width-1:0] mem_wdata;
	logic [data_width-1:0] mem_rdata;
	logic midi_in;
	logic [15:0] led;
	logic midi_busy;
	logic [7:0] seg;
	logic [7:0] an;

	// Outstanding reads in issue order
	logic [data_width-1:0] exp_q[$];
	logic [addr_width-1:0] addr_q[$];
	logic [data_width-1:0] exp_now;
	logic [addr_width-1:0] addr_now;
	logic rd_stage;
	int errors;
	int checks;
	logic [31:0] lcg_state;

	// Shadow copy of RAM contents
	logic [data_width-1:0] shadow [2**ram_addr_bits];
	logic [12:0] wr_addr [32];

	io_system UUT (
		.CLK100MHZ(CLK100MHZ),
		.reset(reset),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.midi_in(midi_in),
		.led(led),
		.midi_busy(midi_busy),
		.seg(seg),
		.an(an)
	);

	// 100 MHz
	initial begin
		CLK100MHZ = 1'b0;
		forever #5 CLK100MHZ = ~CLK100MHZ;
	end

	// LCG with numerical recipes constants
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Reference xorshift step with shifts 13 17 5
	function automatic logic [31:0] xorshift_ref(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Status in the top byte of the 24-bit message
	function automatic logic [31:0] midi_pack(input logic [7:0] status, d1, d2);
		return {8'h00, status, d1, d2};
	endfunction

	// Active-low segments with dp off
	function automatic logic [7:0] seg_ref(input logic [3:0] nib);
		case (nib)
			4'h0: return 8'hC0;
			4'h1: return 8'hF9;
			4'h2: return 8'hA4;
			4'h3: return 8'hB0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hF8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'hA: return 8'h88;
			4'hB: return 8'h83;
			4'hC: return 8'hC6;
			4'hD: return 8'hA1;
			4'hE: return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected, actual);
		errors++;
		$display("FAILED %0t ns: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge CLK100MHZ);
		mem_ren <= 1'b0;
		mem_wen <= 1'b1;
		mem_addr <= addr;
		mem_wdata <= data;
	endtask

	// Queue the expected word along with the request
	task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
		@(posedge CLK100MHZ);
		mem_wen <= 1'b0;
		mem_ren <= 1'b1;
		mem_addr <= addr;
		exp_q.push_back(expected);
		addr_q.push_back(addr);
	endtask

	task automatic bus_idle();
		@(posedge CLK100MHZ);
		mem_ren <= 1'b0;
		mem_wen <= 1'b0;
	endtask

	task automatic drain_reads();
		int n;
		n = 0;
		bus_idle();
		while (exp_q.size() != 0 && n < 10) begin
			@(posedge CLK100MHZ);
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("Timeout: %0d read results never came back", exp_q.size());
		end
	endtask

	// Start bit, data LSB first, stop bit
	task automatic send_midi_byte(input logic [7:0] b);
		@(posedge CLK100MHZ);
		midi_in <= 1'b0;
		repeat (midi_bit_cycles) @(posedge CLK100MHZ);
		// Receiver is mid-frame by now
		checks++;
		if (midi_busy !== 1'b1) begin
			report_mismatch("midi_busy", 32'd1, {31'd0, midi_busy});
		end
		for (int i = 0; i < midi_data_bits; i++) begin
			midi_in <= b[i];
			repeat (midi_bit_cycles) @(posedge CLK100MHZ);
		end
		midi_in <= 1'b1;
		repeat (midi_bit_cycles) @(posedge CLK100MHZ);
	endtask

	task automatic wait_midi_idle();
		int n;
		n = 0;
		while (midi_busy !== 1'b0 && n < 2 * midi_bit_cycles) begin
			@(posedge CLK100MHZ);
			n++;
		end
		if (midi_busy !== 1'b0) begin
			errors++;
			$display("Timeout: MIDI receiver stayed busy after the frame");
		end
	endtask

	// Wait for digit k alone and check its segments
	task automatic check_digit(input int k, input logic [31:0] word);
		int n;
		logic [7:0] target;
		n = 0;
		target = ~(8'h01 << k);
		@(negedge CLK100MHZ);
		while (an !== target && n < 9 * scan_cycles) begin
			@(negedge CLK100MHZ);
			n++;
		end
		if (an !== target) begin
			errors++;
			$display("Timeout: digit %0d never lit on its own", k);
		end else begin
			checks++;
			if (seg !== seg_ref(word[k*4 +: 4])) begin
				report_mismatch($sformatf("seg digit %0d", k),
					{24'd0, seg_ref(word[k*4 +: 4])}, {24'd0, seg});
			end
		end
	endtask

	// Read accepted at this edge is valid after the next
	always @(posedge CLK100MHZ) begin
		rd_stage <= mem_ren && !reset;
	end

	// Compare mid-cycle away from the edges
	always @(negedge CLK100MHZ) begin
		if (rd_stage === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Read data came back with no request waiting for it");
			end else begin
				exp_now = exp_q.pop_front();
				addr_now = addr_q.pop_front();
				checks++;
				if (mem_rdata !== exp_now) begin
					report_mismatch($sformatf("mem_rdata at %h", addr_now),
						exp_now, mem_rdata);
				end
			end
		end
	end

	initial begin : main_seq
		int n;
		logic [31:0] word;
		logic [31:0] rng_exp;
		logic [12:0] a;
		reset = 1'b1;
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		midi_in = 1'b1;
		errors = 0;
		checks = 0;
		lcg_state = 32'h15e5_bc17;
		repeat (4) @(posedge CLK100MHZ);
		reset <= 1'b0;
		// Idle state straight after reset
		@(negedge CLK100MHZ);
		checks += 3;
		if (mem_rdata !== 32'd0) begin
			report_mismatch("mem_rdata", 32'd0, mem_rdata);
		end
		if (led !== 16'd0 || midi_busy !== 1'b0) begin
			report_mismatch("led and midi_busy", 32'd0, {15'd0, midi_busy, led});
		end
		if (an !== 8'hFF) begin
			report_mismatch("an", 32'hFF, {24'd0, an});
		end

		// Random RAM writes over both alias halves
		for (int i = 0; i < 32; i++) begin
			word = next_rand();
			a = word[12:0];
			wr_addr[i] = a;
			word = next_rand();
			shadow[a[11:0]] = word;
			bus_write({19'd0, a}, word);
		end
		// Back-to-back reads with odd ones through the other alias
		for (int i = 0; i < 32; i++) begin
			a = wr_addr[i] ^ {i[0], 12'd0};
			bus_read({19'd0, a}, shadow[a[11:0]]);
		end
		drain_reads();

		// ID word, unmapped I/O and an ignored write
		bus_read(mmio_id_addr, id_word);
		bus_read(mmio_display_addr + 1, 32'd0);
		bus_read(32'h0000_2FFF, 32'd0);
		bus_read(32'hFFFF_FFFF, 32'd0);
		bus_write(mmio_id_addr, 32'h1234_5678);
		bus_read(mmio_id_addr, id_word);
		// Display register still holds its reset value
		bus_read(mmio_display_addr, 32'd0);
		drain_reads();

		// RNG returns the state before each advance
		rng_exp = rng_seed;
		for (int i = 0; i < 8; i++) begin
			bus_read(mmio_rng_addr, rng_exp);
			rng_exp = xorshift_ref(rng_exp);
		end
		drain_reads();

		// Stray data byte latches nothing
		send_midi_byte(8'h45);
		wait_midi_idle();
		bus_read(mmio_midi_addr, 32'd0);
		drain_reads();

		// Note on for channel 4
		word = midi_pack(8'h93, 8'h3C, 8'h64);
		send_midi_byte(8'h93);
		send_midi_byte(8'h3C);
		send_midi_byte(8'h64);
		n = 0;
		while (led !== word[15:0] && n < 4 * midi_bit_cycles) begin
			@(posedge CLK100MHZ);
			n++;
		end
		checks++;
		if (led !== word[15:0]) begin
			errors++;
			$display("Timeout: led never showed the MIDI message %h, still %h",
				word[15:0], led);
		end
		wait_midi_idle();
		bus_read(mmio_midi_addr, word);
		drain_reads();

		// Display readback and every digit of the scan
		word = next_rand();
		bus_write(mmio_display_addr, word);
		bus_read(mmio_display_addr, word);
		drain_reads();
		for (int k = 0; k < 8; k++) begin
			check_digit(k, word);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== io_system.f ====
hw/mmio_pkg.sv
hw/midi_pkg.sv
hw/data_ram.sv
hw/xorshift_rng.sv
hw/midi_receiver.sv
hw/sevenseg_scanner.sv
hw/mmio_bus.sv
hw/io_system.sv
test/io_system_tb.sv
